//--- rd_engine_pkg.sv
package rd_engine_pkg;

    // ==============================
    // Address and data widths
    // ==============================

    // Line address, 64-byte lines
    localparam int LINE_ADDR_WIDTH = 42;
    localparam int BYTE_IDX_WIDTH = 6;
    typedef logic [LINE_ADDR_WIDTH-1:0] t_line_addr;
    typedef logic [LINE_ADDR_WIDTH+BYTE_IDX_WIDTH-1:0] t_byte_addr;

    // One read data beat
    localparam int DATA_WIDTH = 512;
    typedef logic [DATA_WIDTH-1:0] t_data;

    // Offset from base and the wrap mask share one type
    localparam int ADDR_OFFSET_WIDTH = 32;
    typedef logic [ADDR_OFFSET_WIDTH-1:0] t_addr_offset;

    // Burst length in lines; AXI len is this minus one
    localparam int BURST_LEN_WIDTH = 8;
    typedef logic [BURST_LEN_WIDTH-1:0] t_burst_len;

    localparam int NUM_BURSTS_WIDTH = 16;
    typedef logic [NUM_BURSTS_WIDTH-1:0] t_num_bursts;

    // Lines in flight
    localparam int LINE_COUNT_WIDTH = 12;
    typedef logic [LINE_COUNT_WIDTH-1:0] t_line_count;

    // Statistics counters, split in two halves for the adder
    localparam int COUNTER_WIDTH = 48;
    localparam int COUNTER_HALF_WIDTH = COUNTER_WIDTH / 2;
    typedef logic [COUNTER_WIDTH-1:0] t_counter;

    // ==============================
    // Register interface
    // ==============================

    localparam int CSR_DATA_WIDTH = 64;
    localparam int CSR_IDX_WIDTH = 4;
    typedef logic [CSR_DATA_WIDTH-1:0] t_csr_data;
    typedef logic [CSR_IDX_WIDTH-1:0] t_csr_idx;

    // Write side
    typedef enum logic [CSR_IDX_WIDTH-1:0] {
        CFG_BASE_ADDR = 4'd0,
        CFG_RD_CTRL   = 4'd1,
        CFG_ADDR_MASK = 4'd2
    } t_cfg_reg;

    // Read side, anything else reads zero
    typedef enum logic [CSR_IDX_WIDTH-1:0] {
        STAT_INFO        = 4'd0,
        STAT_BURSTS_REQ  = 4'd1,
        STAT_LINES_REQ   = 4'd2,
        STAT_BURSTS_RESP = 4'd3,
        STAT_LINES_RESP  = 4'd4,
        STAT_ACTIVE_SUM  = 4'd5,
        STAT_MAX_ACTIVE  = 4'd6,
        STAT_RD_CHECK    = 4'd7
    } t_stat_reg;

    // RD_CTRL field positions
    localparam int RD_CTRL_CAP_LSB = 48;
    localparam int RD_CTRL_BURSTS_LSB = 32;
    localparam int RD_CTRL_OFFSET_LSB = 16;
    localparam int RD_CTRL_OFFSET_WIDTH = 16;
    localparam int RD_CTRL_LEN_LSB = 0;

    // Reported in STAT_INFO
    localparam int MAX_BURST_LEN = 128;

    // Cycles for a counter to settle after its last increment
    localparam int STAT_SETTLE_CYCLES = 4;

    // ==============================
    // Statistics and FSM types
    // ==============================

    typedef enum int {
        SEL_BURSTS_REQ  = 0,
        SEL_LINES_REQ   = 1,
        SEL_BURSTS_RESP = 2,
        SEL_LINES_RESP  = 3,
        SEL_ACTIVE_SUM  = 4,
        NUM_STATS       = 5
    } t_stat_sel;

    typedef t_counter [NUM_STATS-1:0] t_stat_incr;
    typedef t_counter [NUM_STATS-1:0] t_stat_vals;

    typedef enum logic [1:0] {
        GEN_IDLE,
        GEN_ISSUE,
        GEN_DONE
    } t_gen_state;

endpackage

//--- rd_cfg_if.sv
`timescale 1ns/1ps

// Run configuration from the register file
interface rd_cfg_if import rd_engine_pkg::*; ();

    t_line_addr   base_addr;
    t_addr_offset start_offset;
    t_addr_offset addr_mask;
    t_burst_len   burst_len;
    t_num_bursts  num_bursts;
    // Cap minus one, all ones when unlimited
    t_line_count  max_active;

    modport csr (
        output base_addr, start_offset, addr_mask, burst_len, num_bursts, max_active
    );

    modport gen (
        input base_addr, start_offset, addr_mask, burst_len, num_bursts, max_active
    );

endinterface

// Counter increments, counter values and monitor flags
interface rd_stat_if import rd_engine_pkg::*; ();

    t_stat_incr  incr;
    t_stat_vals  vals;
    // Measured maximum of lines in flight
    t_line_count max_active;
    logic        quota_hit;

    modport src (
        output incr, max_active, quota_hit
    );

    modport dst (
        input incr, vals, max_active
    );

endinterface

//--- stat_counter.sv
`timescale 1ns/1ps

module stat_counter import rd_engine_pkg::*;
(
    input  logic     clk,
    input  logic     state_reset,
    input  t_counter incr_by,
    output t_counter value
);

    logic [COUNTER_HALF_WIDTH-1:0] low_q;
    logic [COUNTER_HALF_WIDTH-1:0] high_q;
    logic [COUNTER_HALF_WIDTH-1:0] incr_high_q;
    logic                          carry_q;

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            low_q <= '0;
            high_q <= '0;
            incr_high_q <= '0;
            carry_q <= 1'b0;
        end
        else
        begin
            // First cycle, low half and its carry
            {carry_q, low_q} <= {1'b0, low_q} + {1'b0, incr_by[COUNTER_HALF_WIDTH-1:0]};
            incr_high_q <= incr_by[COUNTER_WIDTH-1:COUNTER_HALF_WIDTH];

            // Second cycle, high half picks up the carry
            high_q <= high_q + incr_high_q + COUNTER_HALF_WIDTH'(carry_q);
        end
    end

    assign value = {high_q, low_q};

endmodule

//--- rd_resp_hash.sv
`timescale 1ns/1ps

module rd_resp_hash import rd_engine_pkg::*;
(
    input  logic        clk,
    input  logic        state_reset,
    input  logic        r_fire,
    input  t_data       r_data,
    output logic [31:0] hash_value,
    output logic [31:0] hash_sum
);

    logic        beat_valid;
    logic [31:0] beat_word;
    logic [31:0] hash_q;
    logic [31:0] sum_q;

    // Stage one, capture the top and bottom 16 bits of the beat
    always_ff @(posedge clk)
    begin
        beat_word <= {r_data[DATA_WIDTH-1 -: 16], r_data[15:0]};
    end

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            beat_valid <= 1'b0;
            hash_q <= '0;
            sum_q <= '0;
            hash_value <= '0;
            hash_sum <= '0;
        end
        else
        begin
            beat_valid <= r_fire;

            // Stage two, rotate left and fold in
            if (beat_valid)
            begin
                hash_q <= {hash_q[30:0], hash_q[31]} ^ beat_word;
                sum_q <= sum_q + beat_word;
            end

            // Stage three, output registers
            hash_value <= hash_q;
            hash_sum <= sum_q;
        end
    end

endmodule

//--- rd_traffic_monitor.sv
`timescale 1ns/1ps

module rd_traffic_monitor import rd_engine_pkg::*;
(
    input  logic       clk,
    input  logic       state_reset,

    // Channel handshakes
    input  logic       ar_fire,
    input  t_burst_len ar_len,
    input  logic       r_fire,
    input  logic       r_last,

    rd_cfg_if.gen      cfg,
    rd_stat_if.src     stats
);

    t_line_count active_lines;
    t_line_count new_req_lines;

    // Lines added by this cycle's request
    assign new_req_lines = ar_fire ? (t_line_count'(ar_len) + t_line_count'(1)) : '0;

    // ==============================
    // Counter increments
    // ==============================

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            stats.incr <= '0;
        end
        else
        begin
            stats.incr[SEL_BURSTS_REQ] <= t_counter'(ar_fire);
            stats.incr[SEL_LINES_REQ] <= t_counter'(new_req_lines);
            stats.incr[SEL_BURSTS_RESP] <= t_counter'(r_fire && r_last);
            stats.incr[SEL_LINES_RESP] <= t_counter'(r_fire);
            // Little's Law sum of lines in flight
            stats.incr[SEL_ACTIVE_SUM] <= t_counter'(active_lines);
        end
    end

    // ==============================
    // Lines in flight and quota
    // ==============================

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            active_lines <= '0;
            stats.max_active <= '0;
            stats.quota_hit <= 1'b0;
        end
        else
        begin
            // One line returns per beat
            active_lines <= active_lines + new_req_lines - t_line_count'(r_fire);

            // Registered, so one more burst can slip past the cap
            stats.quota_hit <= ((active_lines + new_req_lines) > cfg.max_active);

            if (active_lines > stats.max_active)
            begin
                stats.max_active <= active_lines;
            end
        end
    end

endmodule

//--- rd_req_gen.sv
`timescale 1ns/1ps

module rd_req_gen import rd_engine_pkg::*;
(
    input  logic       clk,
    input  logic       state_reset,
    input  logic       state_run,

    rd_cfg_if.gen      cfg,
    input  logic       quota_hit,

    // AXI read address channel
    output logic       ar_valid,
    input  logic       ar_ready,
    output t_byte_addr ar_addr,
    output t_burst_len ar_len,

    output logic       gen_busy
);

    t_gen_state   state;
    t_addr_offset cur_offset;
    t_num_bursts  bursts_left;
    logic         unlimited;
    logic         ar_fire;

    // Request is offered whenever issuing and under the line cap
    assign gen_busy = (state == GEN_ISSUE);
    assign ar_valid = gen_busy && !quota_hit;
    assign ar_fire = ar_valid && ar_ready;

    // Line address with zero byte index
    assign ar_addr = { cfg.base_addr + t_line_addr'(cur_offset),
                       {BYTE_IDX_WIDTH{1'b0}} };
    assign ar_len = cfg.burst_len - t_burst_len'(1);

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            state <= GEN_IDLE;
            cur_offset <= '0;
            bursts_left <= '0;
            unlimited <= 1'b0;
        end
        else if (!state_run)
        begin
            // Track the configuration while stopped
            state <= GEN_IDLE;
            cur_offset <= cfg.start_offset;
            bursts_left <= cfg.num_bursts;
            unlimited <= (cfg.num_bursts == '0);
        end
        else
        begin
            case (state)
                GEN_IDLE:
                begin
                    // No buffer configured
                    if (cfg.base_addr == '0)
                    begin
                        state <= GEN_DONE;
                    end
                    else
                    begin
                        state <= GEN_ISSUE;
                    end
                end
                GEN_ISSUE:
                begin
                    // Advance only on an accepted burst
                    if (ar_fire)
                    begin
                        cur_offset <= (cur_offset + t_addr_offset'(cfg.burst_len)) &
                                      cfg.addr_mask;
                        bursts_left <= bursts_left - t_num_bursts'(1);

                        if (!unlimited && (bursts_left == t_num_bursts'(1)))
                        begin
                            state <= GEN_DONE;
                        end
                    end
                end
                GEN_DONE:
                begin
                    // Hold until state_run drops
                    state <= GEN_DONE;
                end
                default:
                begin
                    state <= GEN_IDLE;
                end
            endcase
        end
    end

endmodule

//--- rd_engine_csr.sv
`timescale 1ns/1ps

module rd_engine_csr import rd_engine_pkg::*;
(
    input  logic        clk,
    input  logic        state_reset,

    // Register access
    input  logic        csr_wr,
    input  t_csr_idx    csr_idx,
    input  t_csr_data   csr_wdata,
    input  t_csr_idx    csr_rd_idx,
    output t_csr_data   csr_rdata,

    rd_cfg_if.csr       cfg,
    rd_stat_if.dst      stats,

    input  logic        gen_busy,
    input  logic [31:0] hash_value,
    input  logic [31:0] hash_sum,
    output logic        status_active
);

    // ==============================
    // Configuration registers
    // ==============================

    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            cfg.base_addr <= '0;
            cfg.addr_mask <= '1;
            // Control word of zero
            cfg.start_offset <= '0;
            cfg.num_bursts <= '0;
            cfg.burst_len <= '0;
            cfg.max_active <= '1;
        end
        else if (csr_wr)
        begin
            case (t_cfg_reg'(csr_idx))
                CFG_BASE_ADDR:
                begin
                    cfg.base_addr <= t_line_addr'(csr_wdata);
                end
                CFG_RD_CTRL:
                begin
                    // Cap of zero wraps to all ones and means no cap
                    cfg.max_active <= csr_wdata[RD_CTRL_CAP_LSB +: LINE_COUNT_WIDTH] -
                                      t_line_count'(1);
                    cfg.num_bursts <= csr_wdata[RD_CTRL_BURSTS_LSB +: NUM_BURSTS_WIDTH];
                    cfg.start_offset <=
                        t_addr_offset'(csr_wdata[RD_CTRL_OFFSET_LSB +: RD_CTRL_OFFSET_WIDTH]);
                    cfg.burst_len <= csr_wdata[RD_CTRL_LEN_LSB +: BURST_LEN_WIDTH];
                end
                CFG_ADDR_MASK:
                begin
                    cfg.addr_mask <= t_addr_offset'(csr_wdata);
                end
                default:
                begin
                end
            endcase
        end
    end

    // ==============================
    // Status read mux
    // ==============================

    always_comb
    begin
        csr_rdata = '0;

        case (t_stat_reg'(csr_rd_idx))
            STAT_INFO:
            begin
                // Mask width above, max burst below, bit 15 reserved
                csr_rdata = { 32'h0,
                              16'(ADDR_OFFSET_WIDTH),
                              1'b0,
                              15'(MAX_BURST_LEN) };
            end
            STAT_BURSTS_REQ:  csr_rdata = t_csr_data'(stats.vals[SEL_BURSTS_REQ]);
            STAT_LINES_REQ:   csr_rdata = t_csr_data'(stats.vals[SEL_LINES_REQ]);
            STAT_BURSTS_RESP: csr_rdata = t_csr_data'(stats.vals[SEL_BURSTS_RESP]);
            STAT_LINES_RESP:  csr_rdata = t_csr_data'(stats.vals[SEL_LINES_RESP]);
            STAT_ACTIVE_SUM:  csr_rdata = t_csr_data'(stats.vals[SEL_ACTIVE_SUM]);
            STAT_MAX_ACTIVE:  csr_rdata = t_csr_data'(stats.max_active);
            // Checksum high, hash low
            STAT_RD_CHECK:    csr_rdata = { hash_sum, hash_value };
            default:          csr_rdata = '0;
        endcase
    end

    // ==============================
    // Engine activity
    // ==============================

    // Pending burst increment covers the counter lag after the last request
    always_ff @(posedge clk)
    begin
        if (state_reset)
        begin
            status_active <= 1'b0;
        end
        else
        begin
            status_active <= gen_busy ||
                             (stats.incr[SEL_BURSTS_REQ] != '0) ||
                             (stats.vals[SEL_BURSTS_REQ] != stats.vals[SEL_BURSTS_RESP]);
        end
    end

endmodule

//--- rd_engine_top.sv
`timescale 1ns/1ps

module rd_engine_top import rd_engine_pkg::*;
(
    input  logic       clk,
    input  logic       state_reset,
    input  logic       state_run,

    // Register access
    input  logic       csr_wr,
    input  t_csr_idx   csr_idx,
    input  t_csr_data  csr_wdata,
    input  t_csr_idx   csr_rd_idx,
    output t_csr_data  csr_rdata,
    output logic       status_active,

    // AXI read address channel
    output logic       ar_valid,
    input  logic       ar_ready,
    output t_byte_addr ar_addr,
    output t_burst_len ar_len,

    // AXI read data channel, ready is always high
    input  logic       r_valid,
    input  logic       r_last,
    input  t_data      r_data
);

    rd_cfg_if  cfg_bus ();
    rd_stat_if stat_bus ();

    logic        ar_fire;
    logic        r_fire;
    logic        gen_busy;
    logic [31:0] hash_value;
    logic [31:0] hash_sum;

    assign ar_fire = ar_valid && ar_ready;
    assign r_fire = r_valid;

    rd_engine_csr u_csr (
        .clk,
        .state_reset,
        .csr_wr,
        .csr_idx,
        .csr_wdata,
        .csr_rd_idx,
        .csr_rdata,
        .cfg(cfg_bus.csr),
        .stats(stat_bus.dst),
        .gen_busy,
        .hash_value,
        .hash_sum,
        .status_active
    );

    rd_req_gen u_req_gen (
        .clk,
        .state_reset,
        .state_run,
        .cfg(cfg_bus.gen),
        .quota_hit(stat_bus.quota_hit),
        .ar_valid,
        .ar_ready,
        .ar_addr,
        .ar_len,
        .gen_busy
    );

    rd_traffic_monitor u_monitor (
        .clk,
        .state_reset,
        .ar_fire,
        .ar_len,
        .r_fire,
        .r_last,
        .cfg(cfg_bus.gen),
        .stats(stat_bus.src)
    );

    rd_resp_hash u_hash (
        .clk,
        .state_reset,
        .r_fire,
        .r_data,
        .hash_value,
        .hash_sum
    );

    // One counter per statistic
    for (genvar i = 0; i < int'(NUM_STATS); i++)
    begin : g_stat
        stat_counter u_counter (
            .clk,
            .state_reset,
            .incr_by(stat_bus.incr[i]),
            .value(stat_bus.vals[i])
        );
    end

endmodule

//--- tb_rd_engine.sv
`timescale 1ns/1ps

module tb_rd_engine import rd_engine_pkg::*; ();

    localparam int RESET_CYCLES = 10;
    localparam int TIMEOUT_CYCLES = 6000;
    localparam int INFLIGHT_LIMIT = 10;

    logic       clk = 1'b0;
    logic       state_reset;
    logic       state_run;
    logic       csr_wr;
    t_csr_idx   csr_idx;
    t_csr_data  csr_wdata;
    t_csr_idx   csr_rd_idx;
    t_csr_data  csr_rdata;
    logic       status_active;
    logic       ar_valid;
    logic       ar_ready;
    t_byte_addr ar_addr;
    t_burst_len ar_len;
    logic       r_valid;
    logic       r_last;
    t_data      r_data;

    integer seed = 79126;
    int cycle_count = 0;
    int error_count = 0;
    int check_count = 0;
    int mem_latency = 8;
    int inflight = 0;
    int max_inflight = 0;
    longint active_sum = 0;
    int bursts_req_seen = 0;
    int ar_valid_cycles = 0;
    logic addr_check_en = 1'b0;
    logic limit_check_en = 1'b0;
    logic [31:0] model_hash = '0;
    logic [31:0] model_sum = '0;

    // Expected AR addresses and the memory's pending beats
    t_byte_addr exp_addr_q[$];
    t_line_addr beat_line_q[$];
    logic       beat_last_q[$];
    int         beat_due_q[$];

    rd_engine_top UUT (
        .clk,
        .state_reset,
        .state_run,
        .csr_wr,
        .csr_idx,
        .csr_wdata,
        .csr_rd_idx,
        .csr_rdata,
        .status_active,
        .ar_valid,
        .ar_ready,
        .ar_addr,
        .ar_len,
        .r_valid,
        .r_last,
        .r_data
    );

    always #2 clk = ~clk;

    // ==============================
    // Memory model and monitors
    // ==============================

    // Beat carries the line address low and a scrambled copy at the top
    function automatic t_data beat_for_line(input t_line_addr line);
        t_data      d;
        logic [63:0] a;
        a = 64'(line);
        d = '0;
        d[63:0] = a;
        d[DATA_WIDTH-1 -: 64] = a ^ 64'hA5A5A5A5A5A5A5A5;
        return d;
    endfunction

    // Sampled mid-cycle where handshakes complete at the next rising edge
    always @(negedge clk)
    begin
        t_line_addr line;
        cycle_count++;
        if (ar_valid)
            ar_valid_cycles++;
        if (ar_valid && ar_ready && !state_reset)
        begin
            line = ar_addr[BYTE_IDX_WIDTH +: LINE_ADDR_WIDTH];
            for (int i = 0; i <= int'(ar_len); i++)
            begin
                beat_line_q.push_back(line + t_line_addr'(i));
                beat_last_q.push_back(i == int'(ar_len));
                beat_due_q.push_back(cycle_count + mem_latency + i);
            end
            inflight += int'(ar_len) + 1;
            bursts_req_seen++;
            if (addr_check_en)
            begin
                if (exp_addr_q.size() == 0)
                    report_fault("AR request arrived when none was expected");
                else
                    check_addr("ar_addr", ar_addr, exp_addr_q.pop_front());
                check_len("ar_len", ar_len, 8'd3);
            end
        end
        // r_ready is always high so every valid beat is taken
        if (r_valid && !state_reset)
            inflight--;
        if (inflight > max_inflight)
            max_inflight = inflight;
        // Per-cycle sum of lines in flight for the latency counter
        active_sum += inflight;
        if (limit_check_en && (inflight > INFLIGHT_LIMIT))
            report_fault($sformatf("lines in flight reached %0d, above %0d",
                                   inflight, INFLIGHT_LIMIT));
    end

    // Random AR back-pressure and in-order beat return
    always @(posedge clk)
    begin
        logic [31:0] word;
        #0.5;
        ar_ready = (($random(seed) & 1) == 1);
        if ((beat_due_q.size() > 0) && (beat_due_q[0] <= cycle_count))
        begin
            r_valid = 1'b1;
            r_last = beat_last_q.pop_front();
            r_data = beat_for_line(beat_line_q.pop_front());
            void'(beat_due_q.pop_front());
            // Reference hash rotates left then XORs while the sum wraps at 2^32
            word = {r_data[DATA_WIDTH-1 -: 16], r_data[15:0]};
            model_hash = {model_hash[30:0], model_hash[31]} ^ word;
            model_sum = model_sum + word;
        end
        else
        begin
            r_valid = 1'b0;
            r_last = 1'b0;
            r_data = '0;
        end
    end

    always @(negedge clk)
    begin
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Run stopped at cycle %0d before the tests completed", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // ==============================
    // Helper tasks
    // ==============================

    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic apply_reset();
        state_reset = 1'b1;
        inflight = 0;
        max_inflight = 0;
        active_sum = 0;
        bursts_req_seen = 0;
        model_hash = '0;
        model_sum = '0;
        repeat (RESET_CYCLES) next_cycle();
        state_reset = 1'b0;
    endtask

    task automatic report_fault(input string msg);
        error_count++;
        $display("%0t %s", $time, msg);
    endtask

    task automatic check_csr(input string name, input t_csr_data got, input t_csr_data exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input t_byte_addr got, input t_byte_addr exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_len(input string name, input t_burst_len got, input t_burst_len exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic write_reg(input t_cfg_reg idx, input t_csr_data data);
        csr_wr = 1'b1;
        csr_idx = idx;
        csr_wdata = data;
        next_cycle();
        csr_wr = 1'b0;
        // Idle edge lets the stopped generator copy the new settings
        next_cycle();
    endtask

    // Combinational read sampled mid-cycle
    task automatic read_reg(input t_csr_idx idx, output t_csr_data val);
        csr_rd_idx = idx;
        @(negedge clk);
        val = csr_rdata;
        next_cycle();
    endtask

    task automatic expect_reg(input t_stat_reg idx, input t_csr_data exp);
        t_csr_data val;
        read_reg(idx, val);
        check_csr(idx.name(), val, exp);
    endtask

    task automatic wait_active(input logic level);
        while (status_active !== level)
            next_cycle();
    endtask

    task automatic settle();
        repeat (STAT_SETTLE_CYCLES) next_cycle();
    endtask

    function automatic t_csr_data rd_ctrl_word(input int cap, input int bursts,
                                               input int offset, input int len);
        return {16'(cap), 16'(bursts), 16'(offset), 8'h00, 8'(len)};
    endfunction

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d %s finished with %0d errors", num, name, error_count - errs_before);
    endtask

    // ==============================
    // Directed tests
    // ==============================

    task automatic idle_after_reset();
        int errs;
        errs = error_count;
        // Mask width 32 above and burst limit 128 below
        expect_reg(STAT_INFO, 64'h0000_0000_0020_0080);
        for (int i = 1; i <= 7; i++)
            expect_reg(t_stat_reg'(i), '0);
        check_bit("status_active", status_active, 1'b0);
        report_test(1, "reset values", errs);
    endtask

    task automatic wrapped_burst_run();
        int           errs;
        t_addr_offset off;
        errs = error_count;
        write_reg(CFG_BASE_ADDR, 64'h100);
        write_reg(CFG_ADDR_MASK, 64'd31);
        write_reg(CFG_RD_CTRL, rd_ctrl_word(0, 12, 2, 4));
        // Offsets step by the burst length and wrap at the mask
        off = 2;
        for (int i = 0; i < 12; i++)
        begin
            exp_addr_q.push_back({t_line_addr'(42'h100) + t_line_addr'(off),
                                  {BYTE_IDX_WIDTH{1'b0}}});
            off = (off + 4) & 32'd31;
        end
        addr_check_en = 1'b1;
        state_run = 1'b1;
        wait_active(1'b1);
        wait_active(1'b0);
        state_run = 1'b0;
        settle();
        addr_check_en = 1'b0;
        if (exp_addr_q.size() != 0)
            report_fault("fewer AR requests than expected");
        expect_reg(STAT_BURSTS_REQ, 64'd12);
        expect_reg(STAT_LINES_REQ, 64'd48);
        expect_reg(STAT_BURSTS_RESP, 64'd12);
        expect_reg(STAT_LINES_RESP, 64'd48);
        report_test(2, "wrapped burst run", errs);
    endtask

    task automatic read_checksum();
        int errs;
        errs = error_count;
        expect_reg(STAT_RD_CHECK, {model_sum, model_hash});
        report_test(3, "read checksum", errs);
    endtask

    task automatic capped_slow_run();
        int errs;
        errs = error_count;
        apply_reset();
        mem_latency = 30;
        write_reg(CFG_BASE_ADDR, 64'h200);
        write_reg(CFG_RD_CTRL, rd_ctrl_word(6, 8, 0, 4));
        limit_check_en = 1'b1;
        state_run = 1'b1;
        wait_active(1'b1);
        wait_active(1'b0);
        state_run = 1'b0;
        settle();
        limit_check_en = 1'b0;
        mem_latency = 8;
        expect_reg(STAT_MAX_ACTIVE, t_csr_data'(max_inflight));
        if (max_inflight > INFLIGHT_LIMIT)
            report_fault("measured lines in flight went above the cap plus one burst");
        expect_reg(STAT_ACTIVE_SUM, t_csr_data'(active_sum));
        expect_reg(STAT_BURSTS_REQ, 64'd8);
        expect_reg(STAT_LINES_RESP, 64'd32);
        report_test(4, "capped slow run", errs);
    endtask

    task automatic zero_base_run();
        int   errs;
        logic active_seen;
        errs = error_count;
        active_seen = 1'b0;
        write_reg(CFG_BASE_ADDR, 64'h0);
        write_reg(CFG_RD_CTRL, rd_ctrl_word(0, 4, 0, 4));
        ar_valid_cycles = 0;
        state_run = 1'b1;
        repeat (50)
        begin
            next_cycle();
            if (status_active)
                active_seen = 1'b1;
        end
        state_run = 1'b0;
        next_cycle();
        check_bit("status_active", active_seen, 1'b0);
        if (ar_valid_cycles != 0)
            report_fault("AR request issued with a base address of zero");
        report_test(5, "zero base run", errs);
    endtask

    task automatic unlimited_run_stop();
        int        errs;
        int        bursts_before;
        t_csr_data req;
        t_csr_data resp;
        errs = error_count;
        bursts_before = bursts_req_seen;
        write_reg(CFG_BASE_ADDR, 64'h300);
        write_reg(CFG_ADDR_MASK, 64'd63);
        write_reg(CFG_RD_CTRL, rd_ctrl_word(16, 0, 0, 4));
        state_run = 1'b1;
        repeat (200) next_cycle();
        state_run = 1'b0;
        // Generator is idle one edge after the drop
        next_cycle();
        ar_valid_cycles = 0;
        repeat (10) next_cycle();
        if (ar_valid_cycles != 0)
            report_fault("ar_valid stayed high after state_run dropped");
        wait_active(1'b0);
        settle();
        read_reg(STAT_BURSTS_REQ, req);
        read_reg(STAT_BURSTS_RESP, resp);
        check_csr("STAT_BURSTS_REQ", req, t_csr_data'(bursts_req_seen));
        check_csr("STAT_BURSTS_RESP", resp, t_csr_data'(bursts_req_seen));
        if (bursts_req_seen == bursts_before)
            report_fault("no bursts were issued in the unlimited run");
        report_test(6, "unlimited run stop", errs);
    endtask

    initial
    begin
        state_reset = 1'b1;
        state_run = 1'b0;
        csr_wr = 1'b0;
        csr_idx = '0;
        csr_wdata = '0;
        csr_rd_idx = '0;
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r_last = 1'b0;
        r_data = '0;
        apply_reset();
        idle_after_reset();
        wrapped_burst_run();
        read_checksum();
        capped_slow_run();
        zero_base_run();
        unlimited_run_stop();
        $display("tests 6 checks %0d errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

//--- sources.f
rd_engine_pkg.sv
rd_cfg_if.sv
stat_counter.sv
rd_resp_hash.sv
rd_traffic_monitor.sv
rd_req_gen.sv
rd_engine_csr.sv
rd_engine_top.sv
tb_rd_engine.sv

//--- Bender.yml
package:
  name: rd_engine

sources:
  - files:
      - rd_engine_pkg.sv
      - rd_cfg_if.sv
      - stat_counter.sv
      - rd_resp_hash.sv
      - rd_traffic_monitor.sv
      - rd_req_gen.sv
      - rd_engine_csr.sv
      - rd_engine_top.sv
  - target: test
    files:
      - tb_rd_engine.sv
